//--- build.f
+incdir+src
src/cache_pkg.sv
src/sram_bank.sv
src/tag_data_array.sv
src/line_word_mux.sv
src/cache_ctrl.sv
src/dcache_top.sv
verif/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the data cache testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  exit 0
fi
exit 1

//--- src/cache_ctrl.sv
// cache controller FSM with request register and round-robin victim pointer
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  // core side
  input  logic req_i, we_i,
  input  logic [`CACHE_ADDR_W-1:0]     addr_i,
  input  logic [`CACHE_BE_W-1:0]       be_i,
  input  logic [`CACHE_WORD_W-1:0]     wdata_i,
  output logic gnt_o, rvalid_o, busy_o,
  output logic [`CACHE_WORD_W-1:0]     rdata_o,
  // array and mux side
  input  logic [`CACHE_WAYS-1:0]       hit_way_i,
  input  logic [`CACHE_WORD_W-1:0]     rd_word_i,
  input  line_t                        merged_line_i,
  output logic                         arr_rd_o,
  output logic [`CACHE_INDEX_W-1:0]    arr_index_o,
  output logic [`CACHE_TAG_W-1:0]      arr_tag_o,
  output logic [`CACHE_WAYS-1:0]       arr_we_o,
  output line_t                        arr_wline_o,
  output logic [`CACHE_WORD_SEL_W-1:0] word_sel_o,
  output logic [`CACHE_BE_W-1:0]       st_be_o,
  output logic [`CACHE_WORD_W-1:0]     st_wdata_o,
  // memory side
  output logic miss_req_o, miss_we_o,
  output logic [`CACHE_ADDR_W-1:0]     miss_addr_o,
  output logic [`CACHE_BE_W-1:0]       miss_be_o,
  output logic [`CACHE_WORD_W-1:0]     miss_wdata_o,
  input  logic miss_gnt_i, refill_valid_i,
  input  line_t                        refill_line_i
);

  localparam int unsigned VictimW = $clog2(`CACHE_WAYS);

  ctrl_state_e state_d, state_q;
  logic [`CACHE_WAYS-1:0] hit_way_d, hit_way_q, victim_way;
  logic [VictimW-1:0]     victim_d, victim_q;
  // request register
  logic [`CACHE_INDEX_W-1:0]    index_q;
  logic [`CACHE_TAG_W-1:0]      tag_q;
  logic [`CACHE_WORD_SEL_W-1:0] word_sel_q;
  logic                         we_q;

  assign busy_o      = (state_q != IDLE);
  // read index comes straight from the core while idle
  assign arr_index_o = (state_q == IDLE) ? addr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W] : index_q;
  assign arr_tag_o   = tag_q;
  assign word_sel_o  = word_sel_q;
  assign victim_way  = {{(`CACHE_WAYS-1){1'b0}}, 1'b1} << victim_q;
  // loads fetch the whole line and stores go out as one word
  assign miss_we_o    = we_q;
  assign miss_be_o    = st_be_o;
  assign miss_wdata_o = st_wdata_o;
  assign miss_addr_o  = we_q
      ? {tag_q, index_q, word_sel_q, {(`CACHE_OFFSET_W-`CACHE_WORD_SEL_W){1'b0}}}
      : {tag_q, index_q, {`CACHE_OFFSET_W{1'b0}}};

  // --------------------
  // controller FSM
  // --------------------
  always_comb begin : ctrl_fsm
    state_d     = state_q;
    hit_way_d   = hit_way_q;
    victim_d    = victim_q;
    gnt_o       = 1'b0;
    rvalid_o    = 1'b0;
    rdata_o     = rd_word_i;
    arr_rd_o    = 1'b0;
    arr_we_o    = '0;
    arr_wline_o = merged_line_i;
    miss_req_o  = 1'b0;
    case (state_q)
      IDLE: begin
        // accept and read the set speculatively
        if (req_i) begin
          gnt_o    = 1'b1;
          arr_rd_o = 1'b1;
          state_d  = COMPARE;
        end
      end
      COMPARE: begin
        if (|hit_way_i && we_q) begin
          // store needs a second step to write the merged line
          hit_way_d = hit_way_i;
          state_d   = STORE_WRITE;
        end else if (|hit_way_i) begin
          rvalid_o = 1'b1;
          state_d  = IDLE;
        end else begin
          // store misses only write through and do not allocate
          state_d = MISS_REQ;
        end
      end
      STORE_WRITE: begin
        arr_we_o = hit_way_q;
        state_d  = MISS_REQ;
      end
      MISS_REQ: begin
        // held stable under back-pressure
        miss_req_o = 1'b1;
        if (miss_gnt_i) state_d = we_q ? IDLE : REFILL_WAIT;
      end
      REFILL_WAIT: begin
        // critical word is forwarded from the refill line
        rdata_o = refill_line_i[word_sel_q*`CACHE_WORD_W +: `CACHE_WORD_W];
        if (refill_valid_i) begin
          rvalid_o    = 1'b1;
          arr_we_o    = victim_way;
          arr_wline_o = refill_line_i;
          victim_d    = victim_q + 1'b1;
          state_d     = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      hit_way_q <= '0;
      victim_q  <= '0;
    end else begin
      state_q   <= state_d;
      hit_way_q <= hit_way_d;
      victim_q  <= victim_d;
    end
  end

  // payload captured on acceptance
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      {tag_q, index_q, word_sel_q} <= addr_i[`CACHE_ADDR_W-1:`CACHE_OFFSET_W-`CACHE_WORD_SEL_W];
      we_q       <= we_i;
      st_be_o    <= be_i;
      st_wdata_o <= wdata_i;
    end
  end

  // a line lives in at most one way
  hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_way_i))
    else $error("cache_ctrl: tag hit in more than one way");
  refill_in_wait : assert property (
    @(posedge clk_i) disable iff (!rst_ni) refill_valid_i |-> (state_q == REFILL_WAIT)
  ) else $error("cache_ctrl: refill outside REFILL_WAIT");

endmodule

`default_nettype wire

//--- src/cache_defs.svh
// geometry and width macros for the write-through data cache
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// --------------------
// core side widths
// --------------------
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32
`define CACHE_BE_W 4

// --------------------
// array geometry
// --------------------
`define CACHE_LINE_W 128
`define CACHE_WAYS 2
`define CACHE_SETS 16
// address split is tag | index | word select | byte
`define CACHE_OFFSET_W 4
`define CACHE_INDEX_W 4
`define CACHE_TAG_W 24
`define CACHE_WORD_SEL_W 2

`endif

//--- src/cache_pkg.sv
// controller state type plus tag and line entry types
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

  // --------------------
  // array entries
  // --------------------

  // tag bank entry, valid is rewritten as one on every fill
  typedef struct packed {
    logic                    valid;
    logic [`CACHE_TAG_W-1:0] tag;
  } tag_entry_t;

  // one full cache line, word 0 in the low bits
  typedef logic [`CACHE_LINE_W-1:0] line_t;

  // --------------------
  // controller FSM
  // --------------------
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    STORE_WRITE,
    MISS_REQ,
    REFILL_WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/dcache_top.sv
// data cache top level with controller, tag and data array and word mux
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module dcache_top
  import cache_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  // --------------------
  // core port
  // --------------------
  input  logic req_i, we_i,
  input  logic [`CACHE_ADDR_W-1:0] addr_i,
  input  logic [`CACHE_BE_W-1:0]   be_i,
  input  logic [`CACHE_WORD_W-1:0] wdata_i,
  output logic gnt_o, rvalid_o, busy_o,
  output logic [`CACHE_WORD_W-1:0] rdata_o,
  // --------------------
  // memory port
  // --------------------
  output logic miss_req_o, miss_we_o,
  output logic [`CACHE_ADDR_W-1:0] miss_addr_o,
  output logic [`CACHE_BE_W-1:0]   miss_be_o,
  output logic [`CACHE_WORD_W-1:0] miss_wdata_o,
  input  logic miss_gnt_i, refill_valid_i,
  input  line_t                    refill_line_i
);

  // controller to array
  logic arr_rd;
  logic [`CACHE_INDEX_W-1:0] arr_index;
  logic [`CACHE_TAG_W-1:0] arr_tag;
  logic [`CACHE_WAYS-1:0] arr_we, hit_way;
  line_t arr_wline, merged_line;
  line_t [`CACHE_WAYS-1:0] lines;
  // controller to mux
  logic [`CACHE_WORD_SEL_W-1:0] word_sel;
  logic [`CACHE_BE_W-1:0] st_be;
  logic [`CACHE_WORD_W-1:0] st_wdata, rd_word;

  cache_ctrl u_ctrl (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .be_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o, .busy_o,
    .hit_way_i (hit_way), .rd_word_i (rd_word), .merged_line_i (merged_line),
    .arr_rd_o (arr_rd), .arr_index_o (arr_index), .arr_tag_o (arr_tag),
    .arr_we_o (arr_we), .arr_wline_o (arr_wline),
    .word_sel_o (word_sel), .st_be_o (st_be), .st_wdata_o (st_wdata),
    .miss_req_o, .miss_we_o, .miss_addr_o, .miss_be_o, .miss_wdata_o,
    .miss_gnt_i, .refill_valid_i, .refill_line_i
  );

  // one index serves both read and write, the controller never overlaps them
  tag_data_array u_array (
    .clk_i, .rst_ni, .rd_i (arr_rd), .rd_index_i (arr_index), .cmp_tag_i (arr_tag),
    .wr_way_i (arr_we), .wr_index_i (arr_index), .wr_tag_i (arr_tag),
    .wr_line_i (arr_wline), .lines_o (lines), .hit_way_o (hit_way)
  );

  line_word_mux u_mux (
    .lines_i (lines), .hit_way_i (hit_way), .word_sel_i (word_sel),
    .be_i (st_be), .wdata_i (st_wdata),
    .rd_word_o (rd_word), .merged_line_o (merged_line)
  );

endmodule

`default_nettype wire

//--- src/line_word_mux.sv
// hit-way line select, word extraction and store byte merge
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module line_word_mux
  import cache_pkg::*;
(
  input  line_t [`CACHE_WAYS-1:0]       lines_i,
  input  logic [`CACHE_WAYS-1:0]        hit_way_i,
  input  logic [`CACHE_WORD_SEL_W-1:0]  word_sel_i,
  // store bytes of the registered request
  input  logic [`CACHE_BE_W-1:0]        be_i,
  input  logic [`CACHE_WORD_W-1:0]      wdata_i,
  output logic [`CACHE_WORD_W-1:0]      rd_word_o,
  output line_t                         merged_line_o
);

  line_t sel_line;

  // --------------------
  // way select
  // --------------------
  // hit vector is one-hot or zero, so an or-tree is enough
  always_comb begin : way_select
    sel_line = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (hit_way_i[w]) sel_line = sel_line | lines_i[w];
    end
  end

  // addressed word of the hit line
  assign rd_word_o = sel_line[word_sel_i*`CACHE_WORD_W +: `CACHE_WORD_W];

  // --------------------
  // store merge
  // --------------------
  always_comb begin : store_merge
    merged_line_o = sel_line;
    // only enabled bytes of the addressed word change
    for (int b = 0; b < `CACHE_BE_W; b++) begin
      if (be_i[b]) merged_line_o[word_sel_i*`CACHE_WORD_W + b*8 +: 8] = wdata_i[b*8 +: 8];
    end
  end

endmodule

`default_nettype wire

//--- src/sram_bank.sv
// one-read one-write synchronous ram bank with registered read data
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module sram_bank #(
  parameter type entry_t = logic
) (
  input  logic                      clk_i,
  // read port, data appears one cycle later
  input  logic                      rd_i,
  input  logic [`CACHE_INDEX_W-1:0] rd_addr_i,
  // write port, written on the clock edge
  input  logic                      we_i,
  input  logic [`CACHE_INDEX_W-1:0] wr_addr_i,
  input  entry_t                    wdata_i,
  output entry_t                    rdata_o
);

  // one entry per set
  entry_t mem_q [`CACHE_SETS];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[wr_addr_i] <= wdata_i;
    end
  end

  // read data holds until the next read strobe
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rdata_o <= mem_q[rd_addr_i];
    end
  end

  // read-during-write data is undefined on a real macro
  no_rw_same_addr : assert property (
    @(posedge clk_i) !(rd_i && we_i && (rd_addr_i == wr_addr_i))
  ) else $error("sram_bank: read and write to set %0d in one cycle", rd_addr_i);

endmodule

`default_nettype wire

//--- src/tag_data_array.sv
// per-way tag and data banks with valid bits and tag compare
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module tag_data_array
  import cache_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             rd_i,
  input  logic [`CACHE_INDEX_W-1:0]        rd_index_i,
  // tag of the registered request, compared after the read
  input  logic [`CACHE_TAG_W-1:0]          cmp_tag_i,
  input  logic [`CACHE_WAYS-1:0]           wr_way_i,
  input  logic [`CACHE_INDEX_W-1:0]        wr_index_i,
  input  logic [`CACHE_TAG_W-1:0]          wr_tag_i,
  input  line_t                            wr_line_i,
  output line_t [`CACHE_WAYS-1:0]          lines_o,
  output logic [`CACHE_WAYS-1:0]           hit_way_o
);

  // every write stores a valid entry
  tag_entry_t wr_entry;
  assign wr_entry.valid = 1'b1;
  assign wr_entry.tag   = wr_tag_i;

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    tag_entry_t             tag_rd;
    // flop copy of valid so that a reset clears the whole way
    logic [`CACHE_SETS-1:0] valid_q;
    logic                   valid_rd_q;

    sram_bank #(.entry_t(tag_entry_t)) u_tag_bank (
      .clk_i, .rd_i,
      .rd_addr_i (rd_index_i),
      .we_i      (wr_way_i[w]),
      .wr_addr_i (wr_index_i),
      .wdata_i   (wr_entry),
      .rdata_o   (tag_rd)
    );

    sram_bank #(.entry_t(line_t)) u_data_bank (
      .clk_i, .rd_i,
      .rd_addr_i (rd_index_i),
      .we_i      (wr_way_i[w]),
      .wr_addr_i (wr_index_i),
      .wdata_i   (wr_line_i),
      .rdata_o   (lines_o[w])
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q    <= '0;
        valid_rd_q <= 1'b0;
      end else begin
        if (wr_way_i[w]) valid_q[wr_index_i] <= 1'b1;
        // sample with the same latency as the banks
        if (rd_i) valid_rd_q <= valid_q[rd_index_i];
      end
    end

    assign hit_way_o[w] = valid_rd_q & tag_rd.valid & (tag_rd.tag == cmp_tag_i);
  end

endmodule

`default_nettype wire

//--- verif/dcache_stimulus.txt
# op addr be wdata exp_rdata exp_miss, all numbers in hex
# op is L for load or S for store, exp_rdata is unused for stores
L 00001030 0 00000000 C0DE1030 1
L 00001034 0 00000000 C0DE1034 0
L 00001038 0 00000000 C0DE1038 0
L 0000103C 0 00000000 C0DE103C 0
S 00001034 3 1111BEEF 00000000 0
L 00001034 0 00000000 C0DEBEEF 0
S 00002044 F 12345678 00000000 1
L 00002044 0 00000000 12345678 1
S 00002048 4 00AB0000 00000000 0
L 00002048 0 00000000 C0AB2048 0
L 00002040 0 00000000 C0DE2040 0
L 00003050 0 00000000 C0DE3050 1
L 00003154 0 00000000 C0DE3154 1
L 00003258 0 00000000 C0DE3258 1
L 0000315C 0 00000000 C0DE315C 0
L 0000305C 0 00000000 C0DE305C 1
L 00003254 0 00000000 C0DE3254 0
L 0000103C 0 00000000 C0DE103C 0

//--- verif/dcache_tb.sv
// testbench for dcache_top with clock, memory-side model, stimulus file reader and checks
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module dcache_tb
  import cache_pkg::*;
;

  localparam logic [31:0] FillPattern = 32'hC0DE_0000;

  logic clk_i, rst_ni;
  logic req_i, we_i, gnt_o, rvalid_o, busy_o;
  logic [`CACHE_ADDR_W-1:0] addr_i, miss_addr_o;
  logic [`CACHE_BE_W-1:0] be_i, miss_be_o;
  logic [`CACHE_WORD_W-1:0] wdata_i, rdata_o, miss_wdata_o;
  logic miss_req_o, miss_we_o, miss_gnt_i, refill_valid_i;
  line_t refill_line_i;

  // stimulus columns with one entry per file line
  byte               op_q[$];
  logic [31:0]       addr_q[$], wdata_q[$], exp_q[$];
  logic [3:0]        be_q[$];
  logic              miss_q[$];
  // operation in flight as seen by the memory model
  logic              cur_we;
  logic [31:0]       cur_addr, cur_wdata;
  logic [3:0]        cur_be;
  // memory contents that differ from the fill pattern
  logic [31:0]       mem_model [logic [31:0]];
  logic [31:0]       rng_q = 32'd62;
  int                cycle_cnt = 0;
  int                cycle_limit = 1000;

  dcache_top u_dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] a);
    if (mem_model.exists(a)) return mem_model[a];
    return a ^ FillPattern;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // --------------------
  // memory side
  // --------------------
  task automatic serve_miss();
    logic [31:0] req_addr, word;
    int          gnt_delay, refill_delay;
    line_t       line;
    req_addr = miss_addr_o;
    check_value("miss_we_o", {31'd0, miss_we_o}, {31'd0, cur_we});
    // loads fetch the aligned line and stores send one word
    check_value("miss_addr_o", req_addr,
                cur_we ? {cur_addr[31:2], 2'b00} : {cur_addr[31:4], 4'h0});
    if (cur_we) begin
      check_value("miss_be_o", {28'd0, miss_be_o}, {28'd0, cur_be});
      check_value("miss_wdata_o", miss_wdata_o, cur_wdata);
    end
    rng_q = xorshift32(rng_q);
    gnt_delay = rng_q % 32'd6;
    rng_q = xorshift32(rng_q);
    refill_delay = rng_q % 32'd6;
    // request must hold still under back-pressure
    repeat (gnt_delay) begin
      @(negedge clk_i);
      #1;
      check_value("miss_req_o", {31'd0, miss_req_o}, 32'd1);
      check_value("miss_addr_o", miss_addr_o, req_addr);
    end
    @(negedge clk_i);
    miss_gnt_i = 1'b1;
    @(negedge clk_i);
    miss_gnt_i = 1'b0;
    if (cur_we) begin
      word = read_word(req_addr);
      for (int b = 0; b < 4; b++) begin
        if (cur_be[b]) word[b*8 +: 8] = cur_wdata[b*8 +: 8];
      end
      mem_model[req_addr] = word;
    end else begin
      repeat (refill_delay) @(negedge clk_i);
      for (int i = 0; i < 4; i++) begin
        line[i*32 +: 32] = read_word({req_addr[31:4], i[1:0], 2'b00});
      end
      refill_line_i  = line;
      refill_valid_i = 1'b1;
      @(negedge clk_i);
      refill_valid_i = 1'b0;
    end
  endtask

  initial begin : memory_side
    forever begin
      @(negedge clk_i);
      #1;
      if (miss_req_o) serve_miss();
    end
  end

  // --------------------
  // core side
  // --------------------
  task automatic run_op(input int i);
    int cyc;
    int miss_cyc;
    cyc      = 0;
    miss_cyc = 0;
    @(negedge clk_i);
    cur_we    = (op_q[i] == "S");
    cur_addr  = addr_q[i];
    cur_be    = be_q[i];
    cur_wdata = wdata_q[i];
    req_i   = 1'b1;
    we_i    = cur_we;
    addr_i  = cur_addr;
    be_i    = cur_be;
    wdata_i = cur_wdata;
    #1;
    while (!gnt_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    req_i = 1'b0;
    #1;
    cyc = 1;
    // count cycles after gnt until the response or write-through
    while (1) begin
      // busy for the whole operation and no second grant
      check_value("busy_o", {31'd0, busy_o}, 32'd1);
      check_value("gnt_o", {31'd0, gnt_o}, 32'd0);
      if (miss_req_o && miss_cyc == 0) miss_cyc = cyc;
      if (cur_we) check_value("rvalid_o", {31'd0, rvalid_o}, 32'd0);
      if (!cur_we && rvalid_o) break;
      if (cur_we && miss_cyc != 0) break;
      @(negedge clk_i);
      #1;
      cyc++;
    end
    if (cur_we) begin
      // store hit writes the array first and a store miss goes out at once
      check_value("store miss", {31'd0, miss_cyc == 2}, {31'd0, miss_q[i]});
      check_value("miss_req_o cycle", miss_cyc, miss_q[i] ? 32'd2 : 32'd3);
    end else begin
      check_value("load miss", {31'd0, miss_cyc != 0}, {31'd0, miss_q[i]});
      if (miss_q[i]) check_value("miss_req_o cycle", miss_cyc, 32'd2);
      else check_value("rvalid_o cycle", cyc, 32'd1);
      check_value("rdata_o", rdata_o, read_word({cur_addr[31:2], 2'b00}));
      check_value("rdata_o vs file", rdata_o, exp_q[i]);
    end
    while (busy_o) begin
      @(negedge clk_i);
      #1;
    end
  endtask

  initial begin : watchdog
    while (cycle_cnt <= cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Checks failed");
    $fatal(1);
  end

  initial begin : main
    int          fd;
    string       line;
    byte         op;
    logic [31:0] a, wd, ex;
    logic [3:0]  be;
    logic        m;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    be_i = '0;
    wdata_i = '0;
    miss_gnt_i = 1'b0;
    refill_valid_i = 1'b0;
    refill_line_i = '0;
    rst_ni = 1'b0;
    fd = $fopen("verif/dcache_stimulus.txt", "r");
    if (fd == 0) begin
      $display("stimulus file verif/dcache_stimulus.txt could not be opened");
      $display("Checks failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      if ($sscanf(line, "%c %h %h %h %h %h", op, a, be, wd, ex, m) == 6) begin
        op_q.push_back(op);
        addr_q.push_back(a);
        be_q.push_back(be);
        wdata_q.push_back(wd);
        exp_q.push_back(ex);
        miss_q.push_back(m);
      end
    end
    $fclose(fd);
    cycle_limit = 40 * op_q.size() + 8;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("busy_o after reset", {31'd0, busy_o}, 32'd0);
    check_value("miss_req_o after reset", {31'd0, miss_req_o}, 32'd0);
    for (int i = 0; i < op_q.size(); i++) run_op(i);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
